/* Makefile */
TOP = fat_tree_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* build.f */
+incdir+hdl
hdl/fat_tree_pkg.sv
hdl/deflection_arbiter.sv
hdl/tree_switch.sv
hdl/leaf_port.sv
hdl/fat_tree_net.sv
verification/fat_tree_assert.sv
verification/fat_tree_tb.sv

/* hdl/deflection_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module deflection_arbiter #(
	parameter int level = 1
) (
	input fat_tree_pkg::dir_t d_l_i,
	input fat_tree_pkg::dir_t d_r_i,
	input fat_tree_pkg::dir_t d_u_i,
	output fat_tree_pkg::dir_t sel_l_o,
	output fat_tree_pkg::dir_t sel_r_o,
	output fat_tree_pkg::dir_t sel_u_o
);

	if (level == 0) begin : g_root
		// root has no uplink and only left and right children
		always_comb begin
			sel_l_o = fat_tree_pkg::dir_void;
			sel_r_o = fat_tree_pkg::dir_void;
			sel_u_o = fat_tree_pkg::dir_void;
			if (d_l_i == fat_tree_pkg::dir_left)
				sel_l_o = fat_tree_pkg::dir_left;
			if (d_r_i == fat_tree_pkg::dir_right)
				sel_r_o = fat_tree_pkg::dir_right;
			// crossing packets or deflection when both want one side
			if (d_r_i == fat_tree_pkg::dir_left) begin
				if (sel_l_o == fat_tree_pkg::dir_void)
					sel_l_o = fat_tree_pkg::dir_right;
				else
					sel_r_o = fat_tree_pkg::dir_right;
			end
			if (d_l_i == fat_tree_pkg::dir_right) begin
				if (sel_r_o == fat_tree_pkg::dir_void)
					sel_r_o = fat_tree_pkg::dir_left;
				else
					sel_l_o = fat_tree_pkg::dir_left;
			end
		end
	end else begin : g_node
		always_comb begin
			sel_l_o = fat_tree_pkg::dir_void;
			sel_r_o = fat_tree_pkg::dir_void;
			sel_u_o = fat_tree_pkg::dir_void;

			// turnbacks first
			if (d_l_i == fat_tree_pkg::dir_left)
				sel_l_o = fat_tree_pkg::dir_left;
			if (d_r_i == fat_tree_pkg::dir_right)
				sel_r_o = fat_tree_pkg::dir_right;
			if (d_u_i == fat_tree_pkg::dir_up)
				sel_u_o = fat_tree_pkg::dir_up;

			// downlink goes back up if a turnback holds its bus
			if (d_u_i == fat_tree_pkg::dir_left) begin
				if (sel_l_o == fat_tree_pkg::dir_void)
					sel_l_o = fat_tree_pkg::dir_up;
				else
					sel_u_o = fat_tree_pkg::dir_up;
			end else if (d_u_i == fat_tree_pkg::dir_right) begin
				if (sel_r_o == fat_tree_pkg::dir_void)
					sel_r_o = fat_tree_pkg::dir_up;
				else
					sel_u_o = fat_tree_pkg::dir_up;
			end

			// left input wanting the side link or the uplink
			if (d_l_i == fat_tree_pkg::dir_right) begin
				if (sel_r_o == fat_tree_pkg::dir_void)
					sel_r_o = fat_tree_pkg::dir_left;
				else if (sel_l_o == fat_tree_pkg::dir_void)
					sel_l_o = fat_tree_pkg::dir_left;
				else
					sel_u_o = fat_tree_pkg::dir_left;
			end else if (d_l_i == fat_tree_pkg::dir_up) begin
				if (sel_u_o == fat_tree_pkg::dir_void)
					sel_u_o = fat_tree_pkg::dir_left;
				else if (sel_l_o == fat_tree_pkg::dir_void)
					sel_l_o = fat_tree_pkg::dir_left;
				else
					sel_r_o = fat_tree_pkg::dir_left;
			end

			// right input last since at most two buses are taken by now
			if (d_r_i == fat_tree_pkg::dir_left) begin
				if (sel_l_o == fat_tree_pkg::dir_void)
					sel_l_o = fat_tree_pkg::dir_right;
				else if (sel_r_o == fat_tree_pkg::dir_void)
					sel_r_o = fat_tree_pkg::dir_right;
				else
					sel_u_o = fat_tree_pkg::dir_right;
			end else if (d_r_i == fat_tree_pkg::dir_up) begin
				if (sel_u_o == fat_tree_pkg::dir_void)
					sel_u_o = fat_tree_pkg::dir_right;
				else if (sel_r_o == fat_tree_pkg::dir_void)
					sel_r_o = fat_tree_pkg::dir_right;
				else
					sel_l_o = fat_tree_pkg::dir_right;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/fat_tree_consts.svh */
`ifndef FAT_TREE_CONSTS_SVH
`define FAT_TREE_CONSTS_SVH

// network size
`define FT_NUM_LEAVES 4

// destination leaf number
`define FT_ADDR_W 2

// per-packet sequence tag
`define FT_TAG_W 4

// payload carries the source leaf and the tag
`define FT_PAYLOAD_W (`FT_ADDR_W + `FT_TAG_W)

`endif

/* hdl/fat_tree_net.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fat_tree_consts.svh"

module fat_tree_net (
	input wire clk,
	input wire reset,
	input fat_tree_pkg::packet_t inject_i [`FT_NUM_LEAVES],
	output fat_tree_pkg::packet_t eject_o [`FT_NUM_LEAVES],
	output logic [`FT_NUM_LEAVES-1:0] resend_o
);

	// root links indexed by child switch
	fat_tree_pkg::packet_t root_in [2];
	fat_tree_pkg::packet_t root_out [2];

	// level one links with ports left, right and up
	fat_tree_pkg::packet_t sw_in [2][3];
	fat_tree_pkg::packet_t sw_out [2][3];

	tree_switch #(
		.level(0),
		.node_addr(1'b0)
	) u_root (
		.clk(clk),
		.reset(reset),
		.in_i(root_in),
		.out_o(root_out)
	);

	for (genvar s = 0; s < 2; s++) begin : g_node
		assign sw_in[s][2] = root_out[s];
		assign root_in[s] = sw_out[s][2];

		tree_switch #(
			.level(1),
			.node_addr(1'(s))
		) u_switch (
			.clk(clk),
			.reset(reset),
			.in_i(sw_in[s]),
			.out_o(sw_out[s])
		);

		for (genvar k = 0; k < 2; k++) begin : g_leaf
			leaf_port #(
				.leaf_addr(fat_tree_pkg::leaf_addr_t'(2 * s + k))
			) u_leaf (
				.clk(clk),
				.reset(reset),
				.bus_i(sw_out[s][k]),
				.bus_o(sw_in[s][k]),
				.inject_i(inject_i[2 * s + k]),
				.eject_o(eject_o[2 * s + k]),
				.resend_o(resend_o[2 * s + k])
			);
		end
	end

endmodule

`default_nettype wire

/* hdl/fat_tree_pkg.sv */
`default_nettype none

`include "fat_tree_consts.svh"

package fat_tree_pkg;

	typedef logic [`FT_ADDR_W-1:0] leaf_addr_t;

	typedef struct packed {
		leaf_addr_t src;
		logic [`FT_TAG_W-1:0] tag;
	} payload_t;

	// all zero is the empty slot
	typedef struct packed {
		logic valid;
		leaf_addr_t dest;
		payload_t payload;
	} packet_t;

	// wanted direction of an input, or source input of an output
	typedef enum logic [1:0] {
		dir_void = 2'b00,
		dir_left = 2'b01,
		dir_right = 2'b10,
		dir_up = 2'b11
	} dir_t;

	// node_addr holds the node prefix in its low level bits
	function automatic dir_t route_direction(packet_t pkt, int unsigned level,
		leaf_addr_t node_addr);
		logic match;
		match = 1'b1;
		if (!pkt.valid)
			return dir_void;
		for (int i = 0; i < `FT_ADDR_W; i++) begin
			if (i < level && pkt.dest[`FT_ADDR_W-1-i] != node_addr[level-1-i])
				match = 1'b0;
		end
		if (!match)
			return dir_up;
		// next address bit below the prefix picks the child
		return pkt.dest[`FT_ADDR_W-1-level] ? dir_right : dir_left;
	endfunction

endpackage

`default_nettype wire

/* hdl/leaf_port.sv */
`timescale 1ns/1ns
`default_nettype none

module leaf_port #(
	parameter fat_tree_pkg::leaf_addr_t leaf_addr = '0
) (
	input wire clk,
	input wire reset,
	input fat_tree_pkg::packet_t bus_i,
	output fat_tree_pkg::packet_t bus_o,
	input fat_tree_pkg::packet_t inject_i,
	output fat_tree_pkg::packet_t eject_o,
	output logic resend_o
);

	logic accept;
	logic bounce;

	assign accept = bus_i.valid && (bus_i.dest == leaf_addr);

	// a passing packet for another leaf takes the uplink slot
	assign bounce = bus_i.valid && !accept;
	assign resend_o = bounce;

	always_ff @(posedge clk) begin
		if (reset) begin
			eject_o <= '0;
			bus_o <= '0;
		end else begin
			eject_o <= accept ? bus_i : '0;
			if (bounce)
				bus_o <= bus_i;
			else
				bus_o <= inject_i;
		end
	end

endmodule

`default_nettype wire

/* hdl/tree_switch.sv */
`timescale 1ns/1ns
`default_nettype none

module tree_switch #(
	parameter int level = 1,
	parameter logic node_addr = 1'b0,
	localparam int n_ports = (level == 0) ? 2 : 3
) (
	input wire clk,
	input wire reset,
	input fat_tree_pkg::packet_t in_i [n_ports],
	output fat_tree_pkg::packet_t out_o [n_ports]
);

	// port order is left, right, up
	fat_tree_pkg::packet_t in_pad [3];
	fat_tree_pkg::dir_t dir [3];
	fat_tree_pkg::dir_t sel [3];

	for (genvar p = 0; p < 3; p++) begin : g_port
		if (p < n_ports) begin : g_used
			assign in_pad[p] = in_i[p];
		end else begin : g_unused
			// root has no uplink
			assign in_pad[p] = '0;
		end
		assign dir[p] = fat_tree_pkg::route_direction(in_pad[p], level,
			fat_tree_pkg::leaf_addr_t'(node_addr));
	end

	deflection_arbiter #(
		.level(level)
	) u_arb (
		.d_l_i(dir[0]),
		.d_r_i(dir[1]),
		.d_u_i(dir[2]),
		.sel_l_o(sel[0]),
		.sel_r_o(sel[1]),
		.sel_u_o(sel[2])
	);

	// one register stage per hop
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int p = 0; p < n_ports; p++)
				out_o[p] <= '0;
		end else begin
			for (int p = 0; p < n_ports; p++) begin
				case (sel[p])
					fat_tree_pkg::dir_left:
						out_o[p] <= in_pad[0];
					fat_tree_pkg::dir_right:
						out_o[p] <= in_pad[1];
					fat_tree_pkg::dir_up:
						out_o[p] <= in_pad[2];
					default:
						out_o[p] <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verification/fat_tree_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module fat_tree_assert #(
	parameter bit is_switch = 1'b0,
	parameter fat_tree_pkg::leaf_addr_t leaf_addr = '0
) (
	input wire clk,
	input wire reset,
	input wire [2:0] in_valid_i,
	input wire [2:0] out_valid_i,
	input fat_tree_pkg::packet_t eject_i
);

	if (is_switch) begin : g_switch
		// a bufferless hop loses and duplicates nothing
		a_conserve: assert property (@(posedge clk) disable iff (reset)
			$countones(out_valid_i) == $past($countones(in_valid_i)))
			else $error("switch output count differs from its input count a cycle earlier");
	end else begin : g_leaf
		a_eject_dest: assert property (@(posedge clk) disable iff (reset)
			eject_i.valid |-> eject_i.dest == leaf_addr)
			else $error("leaf %0d ejected a packet for leaf %0d", leaf_addr, eject_i.dest);

		a_eject_reset: assert property (@(posedge clk) reset |=> eject_i == '0)
			else $error("leaf %0d eject is not empty after reset", leaf_addr);
	end

endmodule

// root has only two outputs so its third count bit stays low
bind tree_switch fat_tree_assert #(
	.is_switch(1'b1)
) u_assert (
	.clk(clk),
	.reset(reset),
	.in_valid_i({in_pad[2].valid, in_pad[1].valid, in_pad[0].valid}),
	.out_valid_i({(n_ports > 2) && out_o[n_ports-1].valid, out_o[1].valid, out_o[0].valid}),
	.eject_i('0)
);

bind leaf_port fat_tree_assert #(
	.is_switch(1'b0),
	.leaf_addr(leaf_addr)
) u_assert (
	.clk(clk),
	.reset(reset),
	.in_valid_i(3'b000),
	.out_valid_i(3'b000),
	.eject_i(eject_o)
);

`default_nettype wire

/* verification/fat_tree_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fat_tree_consts.svh"

module fat_tree_tb;

	localparam int n_leaves = `FT_NUM_LEAVES;
	localparam int n_tags = 1 << `FT_TAG_W;
	localparam int n_random = 200;
	localparam int drain_limit = 200;
	localparam int offer_limit = 5000;

	logic clk;
	logic reset;
	fat_tree_pkg::packet_t inject [n_leaves];
	fat_tree_pkg::packet_t eject [n_leaves];
	logic [n_leaves-1:0] resend;

	logic [15:0] lfsr_state;
	int cycle;
	int outstanding;
	string test_name;
	// set when the next rising edge takes the offer on inject
	logic [n_leaves-1:0] taken;

	// scoreboard indexed by source leaf and tag
	bit pending [n_leaves][n_tags];
	int pending_dest [n_leaves][n_tags];
	int sent_at [n_leaves][n_tags];
	int latency [n_leaves][n_tags];

	fat_tree_net UUT (
		.clk(clk),
		.reset(reset),
		.inject_i(inject),
		.eject_o(eject),
		.resend_o(resend)
	);

	always #5 clk = ~clk;

	task automatic abort_run(string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic bad_value(string what, int expected, int actual);
		abort_run($sformatf("Mismatch in %s, %s: expected %0d, actual %0d",
			test_name, what, expected, actual));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic int lfsr_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_bit());
		return v;
	endfunction

	task automatic check_ejects();
		int src;
		int tag;
		for (int l = 0; l < n_leaves; l++) begin
			if (eject[l].valid) begin
				src = int'(eject[l].payload.src);
				tag = int'(eject[l].payload.tag);
				assert (int'(eject[l].dest) == l)
					else bad_value("eject destination", l, int'(eject[l].dest));
				assert (pending[src][tag])
					else abort_run($sformatf("%s: leaf %0d ejected source %0d tag %0d %s",
						test_name, l, src, tag, "which is not in flight"));
				assert (pending_dest[src][tag] == l)
					else bad_value("delivery leaf", pending_dest[src][tag], l);
				pending[src][tag] = 1'b0;
				latency[src][tag] = cycle - sent_at[src][tag];
				outstanding--;
			end
		end
	endtask

	// advance to the next falling edge and collect ejected packets
	task automatic next_cycle();
		@(negedge clk);
		cycle++;
		check_ejects();
	endtask

	// drop offers taken at the last edge and hold the others
	task automatic update_offers();
		for (int l = 0; l < n_leaves; l++) begin
			if (inject[l].valid && taken[l])
				inject[l] = '0;
			taken[l] = !resend[l];
		end
	endtask

	task automatic make_packet(int src, int dest, int tag);
		inject[src].valid = 1'b1;
		inject[src].dest = fat_tree_pkg::leaf_addr_t'(dest);
		inject[src].payload.src = fat_tree_pkg::leaf_addr_t'(src);
		inject[src].payload.tag = `FT_TAG_W'(tag);
		pending[src][tag] = 1'b1;
		pending_dest[src][tag] = dest;
		sent_at[src][tag] = cycle;
		outstanding++;
	endtask

	task automatic wait_drain(int limit);
		for (int n = 0; outstanding > 0; n++) begin
			if (n >= limit)
				abort_run($sformatf("%s: %0d packets still in the network after %0d cycles",
					test_name, outstanding, limit));
			else begin
				update_offers();
				next_cycle();
			end
		end
	endtask

	initial begin
		int created;
		int dest;
		int tag;
		clk = 1'b0;
		reset = 1'b1;
		lfsr_state = 16'd63288;
		cycle = 0;
		outstanding = 0;
		taken = '0;
		test_name = "reset";
		for (int l = 0; l < n_leaves; l++)
			inject[l] = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		for (int l = 0; l < n_leaves; l++) begin
			assert (eject[l] == '0)
				else bad_value("eject after reset", 0, int'(eject[l]));
			assert (!resend[l])
				else bad_value("resend after reset", 0, int'(resend[l]));
		end

		test_name = "sibling";
		update_offers();
		make_packet(0, 1, 5);
		next_cycle();
		wait_drain(drain_limit);
		assert (latency[0][5] == 3) else bad_value("latency 0 to 1", 3, latency[0][5]);

		// the two packets cross at the root
		test_name = "cross";
		update_offers();
		make_packet(0, 3, 1);
		make_packet(2, 1, 2);
		next_cycle();
		wait_drain(drain_limit);
		assert (latency[0][1] == 5) else bad_value("latency 0 to 3", 5, latency[0][1]);
		assert (latency[2][2] == 5) else bad_value("latency 2 to 1", 5, latency[2][2]);

		test_name = "contention";
		update_offers();
		make_packet(0, 2, 3);
		make_packet(1, 2, 4);
		next_cycle();
		wait_drain(drain_limit);
		assert (latency[0][3] > 5 || latency[1][4] > 5)
			else abort_run("contention: neither packet was deflected on its way to leaf 2");

		test_name = "random";
		created = 0;
		for (int n = 0; created < n_random; n++) begin
			if (n >= offer_limit)
				abort_run("random: the leaves did not take all offers in time");
			else begin
				update_offers();
				for (int l = 0; l < n_leaves; l++) begin
					if (!inject[l].valid && created < n_random && lfsr_bit()) begin
						dest = lfsr_bits(`FT_ADDR_W);
						tag = lfsr_bits(`FT_TAG_W);
						// skip tags still in flight from this leaf
						for (int k = 0; k < n_tags && pending[l][tag]; k++)
							tag = (tag + 1) % n_tags;
						make_packet(l, dest, tag);
						created++;
					end
				end
				next_cycle();
			end
		end
		wait_drain(drain_limit);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire
